//--- verilog/div_pkg.sv
// shared definitions for the integer divide unit
// widths, word type, operation and state encodings
// request, sign-correction and core result structs

package div_pkg;

   localparam int xlen = 32;
   // four quotient bits are retired per step
   localparam int div_iterations = xlen / 4;

   typedef logic [xlen-1:0] word_t;

   // same order as the low two bits of funct3 for the M extension divides
   typedef enum logic [1:0] {
      op_div,
      op_divu,
      op_rem,
      op_remu
   } div_op_t;

   typedef enum logic [1:0] {
      st_idle,
      st_run,
      st_done
   } div_state_t;

   typedef struct packed {
      div_op_t op;
      word_t   dividend;
      word_t   divisor;
   } div_req_t;

   typedef struct packed {
      logic negate_quotient;
      logic negate_remainder;
      logic want_remainder;
   } div_sign_t;

   typedef struct packed {
      word_t quotient;
      word_t remainder;
      logic  divisor_zero;
   } div_core_out_t;

endpackage

//--- verilog/div_operand_prep.sv
// operand stage of the divide unit
// converts signed operands to magnitudes and derives the
// sign-correction flags used after the unsigned division

`timescale 1ns/1ps

module div_operand_prep (
   input  div_pkg::div_req_t  req,
   output div_pkg::word_t     dividend_mag,
   output div_pkg::word_t     divisor_mag,
   output div_pkg::div_sign_t signs
);

   import div_pkg::*;

   logic is_signed;
   logic want_rem;
   logic dividend_neg;
   logic divisor_neg;

   assign is_signed = (req.op == op_div) || (req.op == op_rem);
   assign want_rem  = (req.op == op_rem) || (req.op == op_remu);

   // operand signs only matter for the signed operations
   assign dividend_neg = is_signed & req.dividend[xlen-1];
   assign divisor_neg  = is_signed & req.divisor[xlen-1];

   // most negative value maps onto itself, which is the right magnitude
   assign dividend_mag = dividend_neg ? -req.dividend : req.dividend;
   assign divisor_mag  = divisor_neg  ? -req.divisor  : req.divisor;

   // quotient sign from both operands, remainder follows the dividend
   assign signs.negate_quotient  = dividend_neg ^ divisor_neg;
   assign signs.negate_remainder = dividend_neg;
   assign signs.want_remainder   = want_rem;

endmodule

//--- verilog/div_radix16_core.sv
// radix-16 restoring divider on unsigned 32-bit operands
// retires one quotient nibble per cycle by comparing the partial
// remainder against all fifteen divisor multiples in parallel
// also reports a zero divisor from the pattern of subtractions

`timescale 1ns/1ps

module div_radix16_core (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start,
   input  logic                  ack,
   input  div_pkg::word_t        dividend,
   input  div_pkg::word_t        divisor,
   output div_pkg::div_core_out_t out,
   output logic                  complete
);

   import div_pkg::*;

   // partial remainder with the next dividend nibble in the low bits
   logic [xlen+3:0] pr;
   word_t           q;
   word_t           b;
   logic [xlen+3:0] b6;
   logic [xlen+3:0] b10;
   logic [xlen+3:0] b12;
   logic [xlen+3:0] b14;
   logic            divisor_zero;

   logic [xlen+3:0] mult [1:15];
   logic [xlen+4:0] diff [1:15];
   logic [15:1]     fits;
   logic [3:0]      digit;
   word_t           rem_next;

   logic [div_iterations-1:0] step_sr;
   logic                      busy;

   //////////////////////////////////////////////////////////////////////
   // divisor multiples
   //////////////////////////////////////////////////////////////////////

   // powers of two are free, odd multiples add one more b
   always_comb begin
      mult[1]  = {4'b0000, b};
      mult[2]  = {3'b000, b, 1'b0};
      mult[3]  = mult[2] + mult[1];
      mult[4]  = {2'b00, b, 2'b00};
      mult[5]  = mult[4] + mult[1];
      mult[6]  = b6;
      mult[7]  = b6 + mult[1];
      mult[8]  = {1'b0, b, 3'b000};
      mult[9]  = mult[8] + mult[1];
      mult[10] = b10;
      mult[11] = b10 + mult[1];
      mult[12] = b12;
      mult[13] = b12 + mult[1];
      mult[14] = b14;
      mult[15] = b14 + mult[1];
   end

   //////////////////////////////////////////////////////////////////////
   // digit selection
   //////////////////////////////////////////////////////////////////////

   // fits is monotonic, so the last multiple that fits is the largest
   always_comb begin
      digit    = 4'h0;
      rem_next = pr[xlen-1:0];
      for (int k = 1; k < 16; k++) begin
         diff[k] = {1'b0, pr} - {1'b0, mult[k]};
         fits[k] = ~diff[k][xlen+4];
         if (fits[k]) begin
            digit    = 4'(k);
            rem_next = diff[k][xlen-1:0];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // datapath registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (start) begin
         b   <= divisor;
         b6  <= {2'b00, divisor, 2'b00} + {3'b000, divisor, 1'b0};
         b10 <= {1'b0, divisor, 3'b000} + {3'b000, divisor, 1'b0};
         b12 <= {1'b0, divisor, 3'b000} + {2'b00, divisor, 2'b00};
         b14 <= {1'b0, divisor, 3'b000} + {2'b00, divisor, 2'b00}
              + {3'b000, divisor, 1'b0};
         pr  <= {{xlen{1'b0}}, dividend[xlen-1:xlen-4]};
         q   <= {dividend[xlen-5:0], 4'b0000};
         // an odd divisor is never zero, which also covers 0xffffffff / 1
         divisor_zero <= ~divisor[0];
      end else if (busy) begin
         pr <= {rem_next, q[xlen-1:xlen-4]};
         q  <= {q[xlen-5:0], digit};
         // a zero divisor lets every subtraction succeed on every step
         divisor_zero <= divisor_zero & (&fits);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // step tracking and completion
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         step_sr  <= '0;
         busy     <= 1'b0;
         complete <= 1'b0;
      end else begin
         step_sr <= {step_sr[div_iterations-2:0], start};
         if (start) begin
            busy <= 1'b1;
         end else if (step_sr[div_iterations-1]) begin
            busy <= 1'b0;
         end
         // complete is held until the requester takes the result
         if (step_sr[div_iterations-1]) begin
            complete <= 1'b1;
         end else if (ack) begin
            complete <= 1'b0;
         end
      end
   end

   assign out.quotient     = q;
   assign out.remainder    = pr[xlen+3:4];
   assign out.divisor_zero = divisor_zero;

endmodule

//--- verilog/div_result_fixup.sv
// result stage of the divide unit
// keeps the sign flags of the accepted request, then restores signs,
// applies the divide-by-zero rule and selects quotient or remainder

`timescale 1ns/1ps

module div_result_fixup (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   accept,
   input  logic                   capture,
   input  div_pkg::div_sign_t     signs,
   input  div_pkg::div_core_out_t core,
   output div_pkg::word_t         result
);

   import div_pkg::*;

   div_sign_t signs_q;
   word_t     corrected;

   // request operands are gone by the time the core finishes
   always_ff @(posedge clk) begin
      if (accept) begin
         signs_q <= signs;
      end
   end

   // zero divisor leaves the dividend magnitude as remainder,
   // so only the quotient needs its own rule
   always_comb begin
      if (signs_q.want_remainder) begin
         corrected = signs_q.negate_remainder ? -core.remainder : core.remainder;
      end else if (core.divisor_zero) begin
         corrected = '1;
      end else begin
         corrected = signs_q.negate_quotient ? -core.quotient : core.quotient;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         result <= '0;
      end else if (capture) begin
         result <= corrected;
      end
   end

endmodule

//--- verilog/div_control.sv
// control FSM of the divide unit
// accepts a start strobe in idle, waits for the core, loads the
// result stage and holds done until ack

`timescale 1ns/1ps

module div_control (
   input  logic clk,
   input  logic rst,
   input  logic start,
   input  logic ack,
   input  logic core_complete,
   output logic core_start,
   output logic core_ack,
   output logic accept,
   output logic capture,
   output logic done
);

   import div_pkg::*;

   div_state_t state;
   div_state_t state_next;

   always_comb begin
      state_next = state;
      case (state)
         st_idle: begin
            if (start) begin
               state_next = st_run;
            end
         end
         st_run: begin
            if (core_complete) begin
               state_next = st_done;
            end
         end
         st_done: begin
            if (ack) begin
               state_next = st_idle;
            end
         end
         default: begin
            state_next = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         state <= state_next;
      end
   end

   // starts outside idle are dropped here
   assign core_start = (state == st_idle) && start;
   assign accept     = core_start;

   // one-cycle capture, which also clears the core's complete
   assign capture  = (state == st_run) && core_complete;
   assign core_ack = capture;

   assign done = (state == st_done);

endmodule

//--- verilog/div_unit.sv
// top level of the 32-bit integer divide unit
// div, divu, rem and remu with a start, done and ack handshake
// operand prep -> radix-16 core -> result fixup, under one FSM

`timescale 1ns/1ps

module div_unit (
   input  logic              clk,
   input  logic              rst,
   input  logic              start,
   input  div_pkg::div_req_t req,
   input  logic              ack,
   output div_pkg::word_t    result,
   output logic              done
);

   import div_pkg::*;

   word_t         dividend_mag;
   word_t         divisor_mag;
   div_sign_t     signs;
   div_core_out_t core_out;
   logic          core_start;
   logic          core_ack;
   logic          core_complete;
   logic          accept;
   logic          capture;

   div_control i_control (
      .clk           (clk),
      .rst           (rst),
      .start         (start),
      .ack           (ack),
      .core_complete (core_complete),
      .core_start    (core_start),
      .core_ack      (core_ack),
      .accept        (accept),
      .capture       (capture),
      .done          (done)
   );

   div_operand_prep i_prep (
      .req          (req),
      .dividend_mag (dividend_mag),
      .divisor_mag  (divisor_mag),
      .signs        (signs)
   );

   div_radix16_core i_core (
      .clk      (clk),
      .rst      (rst),
      .start    (core_start),
      .ack      (core_ack),
      .dividend (dividend_mag),
      .divisor  (divisor_mag),
      .out      (core_out),
      .complete (core_complete)
   );

   div_result_fixup i_fixup (
      .clk     (clk),
      .rst     (rst),
      .accept  (accept),
      .capture (capture),
      .signs   (signs),
      .core    (core_out),
      .result  (result)
   );

endmodule

//--- tb/div_unit_assert.sv
// bound checker for the divide unit
// reference model of div, divu, rem and remu from the M extension rules
// assertions on latency, result value, hold under back-pressure and release

`timescale 1ns/1ps

module div_unit_assert (
   input logic              clk,
   input logic              rst,
   input logic              accept,
   input logic              ack,
   input div_pkg::div_req_t req,
   input div_pkg::word_t    result,
   input logic              done
);

   import div_pkg::*;

   div_req_t req_q;
   word_t    expected;
   int       fail_count = 0;

   // zero divisor rule first, then most negative by minus one
   function automatic word_t expected_result(div_req_t r);
      logic ovf;
      ovf = (r.dividend == 32'h8000_0000) && (r.divisor == '1);
      case (r.op)
         op_divu: return (r.divisor == '0) ? '1 : r.dividend / r.divisor;
         op_remu: return (r.divisor == '0) ? r.dividend : r.dividend % r.divisor;
         op_div:  return (r.divisor == '0) ? '1 : ovf ? r.dividend
                     : word_t'($signed(r.dividend) / $signed(r.divisor));
         default: return (r.divisor == '0) ? r.dividend : ovf ? '0
                     : word_t'($signed(r.dividend) % $signed(r.divisor));
      endcase
   endfunction

   // operands of the request that the unit actually took
   always_ff @(posedge clk) begin
      if (accept) begin
         req_q <= req;
      end
   end

   always_comb begin
      expected = expected_result(req_q);
   end

   latency_exact: assert property (@(posedge clk) disable iff (rst)
         accept |-> ##9 !done ##1 done)
      else begin
         $error("done did not rise exactly 9 edges after an accepted start");
         fail_count++;
      end

   result_matches: assert property (@(posedge clk) disable iff (rst)
         done |-> result == expected)
      else begin
         $error("ERR %0t result: expected %h got %h", $time, expected, result);
         fail_count++;
      end

   held_until_ack: assert property (@(posedge clk) disable iff (rst)
         done && !ack |=> done && $stable(result))
      else begin
         $error("done or result changed while ack was withheld");
         fail_count++;
      end

   released_on_ack: assert property (@(posedge clk) disable iff (rst)
         done && ack |=> !done)
      else begin
         $error("done stayed high on the edge after ack");
         fail_count++;
      end

endmodule

//--- tb/div_unit_tb.sv
// testbench for the divide unit
// LFSR operands for all four operations, divide by zero, signed overflow,
// starts while busy and withheld ack; values are checked by the bound
// assertion module, one line per test and a closing count line

`timescale 1ns/1ps

module div_unit_tb;

   import div_pkg::*;

   logic     clk = 1'b0;
   logic     rst = 1'b1;
   logic     start = 1'b0;
   logic     ack = 1'b0;
   div_req_t req = '0;
   word_t    result;
   logic     done;
   word_t    lfsr = 32'hca26ca41;
   int       tests = 0;
   int       failed = 0;
   int       tb_errors = 0;

   div_unit i_dut (
      .clk    (clk),
      .rst    (rst),
      .start  (start),
      .req    (req),
      .ack    (ack),
      .result (result),
      .done   (done)
   );

   bind div_unit div_unit_assert i_assert (
      .clk    (clk),
      .rst    (rst),
      .accept (accept),
      .ack    (ack),
      .req    (req),
      .result (result),
      .done   (done)
   );

   initial begin
      forever begin
         #2 clk = ~clk;
      end
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic word_t lfsr_step(word_t s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic random_bits(input int n, output word_t v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // one division, from start strobe to ack
   //////////////////////////////////////////////////////////////////////

   task automatic run_division(input div_op_t op, input word_t a, input word_t b,
                               input logic busy_start);
      int    edges;
      int    errs_before;
      word_t hold;
      errs_before = tb_errors + i_dut.i_assert.fail_count;
      random_bits(4, hold);
      req = '{op: op, dividend: a, divisor: b};
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      edges = 0;
      while (!done && edges < 40) begin
         @(negedge clk);
         edges++;
         // a second strobe in the middle of the run must be dropped
         start = busy_start && (edges == 3);
         if (start) begin
            req.dividend = ~a;
         end
      end
      start = 1'b0;
      if (!done) begin
         $display("timeout: done did not rise within 40 cycles of start");
         tb_errors++;
      end else if (edges != 9) begin
         $display("ERR %0t done latency: expected 9 got %0d", $time, edges);
         tb_errors++;
      end
      repeat (int'(hold)) @(negedge clk);
      ack = 1'b1;
      @(negedge clk);
      ack = 1'b0;
      edges = 0;
      while (done && edges < 10) begin
         @(negedge clk);
         edges++;
      end
      if (done) begin
         $display("timeout: done stayed high after ack");
         tb_errors++;
      end
      tests++;
      if (tb_errors + i_dut.i_assert.fail_count != errs_before) begin
         failed++;
      end
      $display("test %0d %s a=%h b=%h result=%h hold=%0d %s", tests, op.name(), a, b,
               result, hold, (tb_errors + i_dut.i_assert.fail_count != errs_before)
               ? "failed" : "ok");
   endtask

   initial begin
      word_t a;
      word_t b;
      word_t s;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      if (done !== 1'b0) begin
         $display("ERR %0t done: expected 0 got %b", $time, done);
         tb_errors++;
      end
      // unsigned operations with the divisor width varied by a random shift
      for (int i = 0; i < 6; i++) begin
         random_bits(32, a);
         random_bits(32, b);
         random_bits(5, s);
         run_division(i[0] ? op_remu : op_divu, a, b >> s, i == 2);
      end
      // signed operations where bit 1 picks the dividend sign and bit 2 the divisor sign
      for (int i = 0; i < 8; i++) begin
         random_bits(32, a);
         random_bits(32, b);
         random_bits(5, s);
         a[31] = i[1];
         b = (b >> s) | 32'h1;
         b[31] = 1'b0;
         if (i[2]) begin
            b = -b;
         end
         run_division(i[0] ? op_rem : op_div, a, b, i == 5);
      end
      for (int i = 0; i < 4; i++) begin
         random_bits(32, a);
         run_division(div_op_t'(i), a, '0, 1'b0);
      end
      run_division(op_div, 32'h8000_0000, 32'hffff_ffff, 1'b1);
      run_division(op_rem, 32'h8000_0000, 32'hffff_ffff, 1'b0);
      @(negedge clk);
      @(negedge clk);
      $display("tests %0d, failed %0d, assertion failures %0d, testbench errors %0d",
               tests, failed, i_dut.i_assert.fail_count, tb_errors);
      if (failed == 0 && tb_errors == 0 && i_dut.i_assert.fail_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- div_unit.f
verilog/div_pkg.sv
verilog/div_operand_prep.sv
verilog/div_radix16_core.sv
verilog/div_result_fixup.sv
verilog/div_control.sv
verilog/div_unit.sv
tb/div_unit_assert.sv
tb/div_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILELIST  ?= div_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
